// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run tb_board with Verilator, then search the log for the pass line
set -u
cd "$(dirname "$0")"

log=sim.log

verilator --binary --timing --assert --top-module tb_board -Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_board +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation completed successfully" "$log"; then
    exit 0
fi
exit 1

// ==== sim.f ====
source/board_pkg.sv
source/uart_pkg.sv
source/byte_link_if.sv
source/slow_clk_gen.sv
source/uart_receiver.sv
source/uart_transmitter.sv
source/top.sv
source/board_specific_top.sv
test/tb_assertions.sv
test/tb_board.sv

// ==== source/board_pkg.sv ====
`default_nettype none

package board_pkg;

    //##########################################################################
    // board level constants
    //##########################################################################

    localparam int clk_mhz     = 50;  // sysclk oscillator
    localparam int w_key       = 2;   // push buttons
    localparam int w_led       = 2;   // plain leds
    localparam int slow_clk_hz = 1;   // blink rate of led[0]

endpackage

`default_nettype wire

// ==== source/board_specific_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_specific_top #(
    parameter int clk_mhz     = board_pkg::clk_mhz,
    parameter int w_key       = board_pkg::w_key,
    parameter int w_led       = board_pkg::w_led,
    parameter int slow_clk_hz = board_pkg::slow_clk_hz
) (
    input  logic               sysclk,
    input  logic               rst_n,
    input  logic [w_key - 1:0] btn,
    output logic [w_led - 1:0] led,
    output logic               led0_b,
    output logic               led0_g,
    output logic               led0_r,
    inout  wire  [7:0]         ja,
    input  logic               uart_txd_in,
    output logic               uart_rxd_out
);

    logic clk;
    logic slow_clk;

    assign clk = sysclk;

    slow_clk_gen #(
        .fast_clk_mhz ( clk_mhz     ),
        .slow_clk_hz  ( slow_clk_hz )
    ) i_slow_clk_gen (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .slow_clk ( slow_clk )
    );

    top i_top (
        .clk         ( clk          ),
        .slow_clk    ( slow_clk     ),
        .rst_n       ( rst_n        ),
        .key         ( btn          ),
        .led         ( led          ),
        .frame_error ( led0_r       ),  // red on bad frame
        .tx_active   ( led0_g       ),  // green while echoing
        .uart_rx     ( uart_txd_in  ),
        .uart_tx     ( uart_rxd_out )
    );

    assign led0_b = 1'b0;
    assign ja     = 'z;  // header unused

endmodule

`default_nettype wire

// ==== source/byte_link_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// byte stream with credit returns flowing back from the consumer
interface byte_link_if;

    logic            valid;   // one cycle per byte
    uart_pkg::byte_t data;
    logic            error;   // framing error on this byte
    logic            credit;  // one slot freed at the consumer

    modport sender (
        output valid,
        output data,
        output error,
        input  credit
    );

    modport receiver (
        input  valid,
        input  data,
        input  error,
        output credit
    );

endinterface

`default_nettype wire

// ==== source/slow_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module slow_clk_gen #(
    parameter int fast_clk_mhz = board_pkg::clk_mhz,
    parameter int slow_clk_hz  = board_pkg::slow_clk_hz
) (
    input  logic clk,
    input  logic rst_n,
    output logic slow_clk
);

    // cycles between two edges of slow_clk
    localparam int half_period = fast_clk_mhz * 1_000_000 / (2 * slow_clk_hz);
    localparam int cnt_w       = (half_period > 1) ? $clog2(half_period) : 1;

    logic [cnt_w - 1:0] cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt      <= '0;
            slow_clk <= 1'b0;
        end else if (cnt == cnt_w'(half_period - 1)) begin
            cnt      <= '0;
            slow_clk <= ~slow_clk;  // half period done
        end else begin
            cnt      <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/top.sv ====
`timescale 1ns/1ps
`default_nettype none

module top (
    input  logic                         clk,
    input  logic                         slow_clk,
    input  logic                         rst_n,
    input  logic [board_pkg::w_key - 1:0] key,
    output logic [board_pkg::w_led - 1:0] led,
    output logic                         frame_error,
    output logic                         tx_active,
    input  logic                         uart_rx,
    output logic                         uart_tx
);

    byte_link_if rx_link ();
    byte_link_if tx_link ();

    uart_pkg::credit_cnt_t tx_credit_cnt;
    uart_pkg::credit_cnt_t credit_next;
    logic                  tx_valid;
    uart_pkg::byte_t       tx_data;
    logic                  err_flag;

    function automatic uart_pkg::byte_t to_upper(input uart_pkg::byte_t b);
        if (b >= 8'h61 && b <= 8'h7a)  // 'a' .. 'z'
            return b - 8'h20;
        return b;
    endfunction

    //##########################################################################
    // lab logic
    //##########################################################################

    // count after this cycle's spend and return
    assign credit_next = tx_credit_cnt - uart_pkg::credit_cnt_t'(tx_valid)
                         + uart_pkg::credit_cnt_t'(tx_link.credit);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_credit_cnt <= uart_pkg::credit_cnt_t'(uart_pkg::tx_credits);
            tx_valid      <= 1'b0;
            err_flag      <= 1'b0;
        end else begin
            tx_credit_cnt <= credit_next;
            tx_valid      <= rx_link.valid && !rx_link.error && (credit_next != '0);
            if (rx_link.valid && rx_link.error)
                err_flag <= 1'b1;  // sticky
            else if (key[1])
                err_flag <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_link.valid)
            tx_data <= key[0] ? to_upper(rx_link.data) : rx_link.data;
    end

    assign rx_link.credit = 1'b0;  // line cannot stall
    assign tx_link.valid  = tx_valid;
    assign tx_link.data   = tx_data;
    assign tx_link.error  = 1'b0;

    //##########################################################################
    // uart
    //##########################################################################

    uart_receiver i_uart_receiver (
        .clk   ( clk     ),
        .rst_n ( rst_n   ),
        .rx    ( uart_rx ),
        .link  ( rx_link )
    );

    uart_transmitter i_uart_transmitter (
        .clk   ( clk       ),
        .rst_n ( rst_n     ),
        .link  ( tx_link   ),
        .tx    ( uart_tx   ),
        .busy  ( tx_active )
    );

    always_comb begin
        led    = '0;
        led[0] = slow_clk;
        led[1] = err_flag;
    end

    assign frame_error = err_flag;

endmodule

`default_nettype wire

// ==== source/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

    //##########################################################################
    // framing
    //##########################################################################

    typedef logic [7:0] byte_t;

    localparam int data_bits  = $bits(byte_t);
    localparam int frame_bits = data_bits + 2;  // start + data + stop

    localparam int baud_rate    = 1_000_000;
    localparam int clks_per_bit = board_pkg::clk_mhz * 1_000_000 / baud_rate;

    //##########################################################################
    // flow control into the transmitter
    //##########################################################################

    localparam int tx_credits = 4;  // queue depth and initial credit count

    typedef logic [$clog2(tx_credits + 1) - 1:0] credit_cnt_t;

endpackage

`default_nettype wire

// ==== source/uart_receiver.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_receiver (
    input  logic clk,
    input  logic rst_n,
    input  logic rx,
    byte_link_if.sender link
);

    localparam int cnt_w    = $clog2(uart_pkg::clks_per_bit);
    localparam int idx_w    = $clog2(uart_pkg::data_bits);
    localparam int half_bit = uart_pkg::clks_per_bit / 2;

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } state_t;

    state_t             state;
    logic               rx_meta;
    logic               rx_sync;
    logic               rx_prev;
    logic [cnt_w - 1:0] clk_cnt;
    logic [idx_w - 1:0] bit_idx;
    logic               bit_tick;
    logic               valid_q;
    logic               error_q;
    uart_pkg::byte_t    shift_q;

    assign bit_tick = (clk_cnt == cnt_w'(uart_pkg::clks_per_bit - 1));

    //##########################################################################
    // frame FSM
    //##########################################################################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;  // line idles high
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
            state   <= st_idle;
            clk_cnt <= '0;
            bit_idx <= '0;
            valid_q <= 1'b0;
            error_q <= 1'b0;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
            valid_q <= 1'b0;
            case (state)
                st_idle: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (rx_prev && !rx_sync)
                        state <= st_start;  // falling edge
                end
                st_start: begin
                    if (clk_cnt == cnt_w'(half_bit - 1)) begin
                        clk_cnt <= '0;
                        state   <= rx_sync ? st_idle : st_data;  // glitch check
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (bit_tick) begin
                        clk_cnt <= '0;
                        if (bit_idx == idx_w'(uart_pkg::data_bits - 1))
                            state <= st_stop;
                        else
                            bit_idx <= bit_idx + 1'b1;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: begin
                    if (bit_tick) begin
                        valid_q <= 1'b1;
                        error_q <= ~rx_sync;  // stop bit must be 1
                        state   <= st_idle;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clk) begin
        if (state == st_data && bit_tick)
            shift_q <= {rx_sync, shift_q[uart_pkg::data_bits - 1:1]};
    end

    assign link.valid = valid_q;
    assign link.data  = shift_q;
    assign link.error = error_q;

endmodule

`default_nettype wire

// ==== source/uart_transmitter.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_transmitter (
    input  logic clk,
    input  logic rst_n,
    byte_link_if.receiver link,
    output logic tx,
    output logic busy
);

    localparam int cnt_w = $clog2(uart_pkg::clks_per_bit);
    localparam int bit_w = $clog2(uart_pkg::frame_bits);
    localparam int ptr_w = $clog2(uart_pkg::tx_credits);

    uart_pkg::byte_t               mem [uart_pkg::tx_credits];
    logic [ptr_w - 1:0]            wr_ptr;
    logic [ptr_w - 1:0]            rd_ptr;
    uart_pkg::credit_cnt_t         fill;
    logic [cnt_w - 1:0]            clk_cnt;
    logic [bit_w - 1:0]            bit_cnt;
    logic [uart_pkg::data_bits:0]  shift_q;  // data plus stop bit
    logic                          credit_q;
    logic                          bit_tick;
    logic                          last_bit;
    logic                          frame_done;
    logic                          deq;

    function automatic logic [ptr_w - 1:0] ptr_inc(input logic [ptr_w - 1:0] p);
        return (p == ptr_w'(uart_pkg::tx_credits - 1)) ? '0 : p + 1'b1;
    endfunction

    assign bit_tick   = (clk_cnt == cnt_w'(uart_pkg::clks_per_bit - 1));
    assign last_bit   = (bit_cnt == bit_w'(uart_pkg::frame_bits - 1));
    assign frame_done = busy && bit_tick && last_bit;
    assign deq        = (!busy || frame_done) && (fill != '0);  // next frame back to back

    //##########################################################################
    // byte queue
    //##########################################################################

    always_ff @(posedge clk) begin
        if (link.valid)
            mem[wr_ptr] <= link.data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill     <= '0;
            credit_q <= 1'b0;
        end else begin
            if (link.valid)
                wr_ptr <= ptr_inc(wr_ptr);
            if (deq)
                rd_ptr <= ptr_inc(rd_ptr);
            fill     <= fill + uart_pkg::credit_cnt_t'(link.valid)
                             - uart_pkg::credit_cnt_t'(deq);
            credit_q <= deq;  // slot handed back
        end
    end

    //##########################################################################
    // shift-out engine
    //##########################################################################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx      <= 1'b1;
            busy    <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (deq) begin
            tx      <= 1'b0;  // start bit
            busy    <= 1'b1;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (busy) begin
            if (bit_tick) begin
                clk_cnt <= '0;
                if (last_bit) begin
                    busy    <= 1'b0;
                end else begin
                    tx      <= shift_q[0];
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (deq)
            shift_q <= {1'b1, mem[rd_ptr]};
        else if (busy && bit_tick && !last_bit)
            shift_q <= shift_q >> 1;
    end

    assign link.credit = credit_q;

endmodule

`default_nettype wire

// ==== test/tb_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_assertions (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  rx_valid,
    input logic                  rx_error,
    input logic                  tx_valid,
    input uart_pkg::credit_cnt_t credit_cnt,
    input logic                  uart_tx,
    input logic                  tx_active
);

    int fail_cnt = 0;  // failed properties so far

    //##########################################################################
    // credit link into the transmitter
    //##########################################################################

    // every good byte from the receiver finds a free credit
    good_byte_forwarded: assert property (@(posedge clk) disable iff (!rst_n)
        rx_valid && !rx_error |=> tx_valid)
        else begin
            fail_cnt++;
            $error("good received byte dropped for lack of a credit");
        end

    credit_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        credit_cnt <= uart_pkg::credit_cnt_t'(uart_pkg::tx_credits))
        else begin
            fail_cnt++;
            $error("credit count above the transmitter queue depth");
        end

    // line idles high between frames
    idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
        !tx_active |-> uart_tx)
        else begin
            fail_cnt++;
            $error("uart_tx low while the transmitter is not busy");
        end

endmodule

bind top tb_assertions u_assertions (
    .clk        ( clk           ),
    .rst_n      ( rst_n         ),
    .rx_valid   ( rx_link.valid ),
    .rx_error   ( rx_link.error ),
    .tx_valid   ( tx_valid      ),
    .credit_cnt ( tx_credit_cnt ),
    .uart_tx    ( uart_tx       ),
    .tx_active  ( tx_active     )
);

`default_nettype wire

// ==== test/tb_board.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_board;

    localparam int cpb        = uart_pkg::clks_per_bit;
    localparam int n_sent     = 16 + 32 + 12 + 2;  // frames into the dut
    localparam int n_echo     = n_sent - 1;        // bad frame gets no echo
    localparam int max_cycles = (n_sent + n_echo) * 10 * cpb + 2000;

    logic            sysclk = 1'b0;
    logic            rst_n;
    logic [1:0]      btn;
    logic [1:0]      led;
    logic            led0_b;
    logic            led0_g;
    logic            led0_r;
    logic            uart_txd_in;
    logic            uart_rxd_out;
    wire  [7:0]      ja;
    uart_pkg::byte_t exp_q [$];
    uart_pkg::byte_t got_q [$];
    logic [31:0]     rng    = 32'hd644_35eb;
    int              cycles = 0;
    int              errors = 0;
    int              tests  = 0;
    int              passed = 0;

    board_specific_top #(
        .slow_clk_hz ( 100_000 )
    ) dut (
        .sysclk       ( sysclk       ),
        .rst_n        ( rst_n        ),
        .btn          ( btn          ),
        .led          ( led          ),
        .led0_b       ( led0_b       ),
        .led0_g       ( led0_g       ),
        .led0_r       ( led0_r       ),
        .ja           ( ja           ),
        .uart_txd_in  ( uart_txd_in  ),
        .uart_rxd_out ( uart_rxd_out )
    );

    always #10 sysclk = ~sysclk;

    always @(posedge sysclk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: the echo did not finish within %0d cycles", max_cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic uart_pkg::byte_t xorshift_byte();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng[7:0];
    endfunction

    //##########################################################################
    // uart line drive and echo decoder
    //##########################################################################

    task automatic send_frame(input uart_pkg::byte_t b, input logic stop);
        logic [9:0] bits;
        bits = {stop, b, 1'b0};  // start bit first, lsb first
        for (int i = 0; i < 10; i++) begin
            uart_txd_in = bits[i];
            repeat (cpb) @(negedge sysclk);
        end
    endtask

    task automatic send_echoed(input uart_pkg::byte_t b, input uart_pkg::byte_t exp);
        exp_q.push_back(exp);
        send_frame(b, 1'b1);
    endtask

    always begin : rx_decoder
        uart_pkg::byte_t b;
        @(negedge uart_rxd_out);
        repeat (cpb / 2) @(negedge sysclk);  // middle of start bit
        assert (led0_g === 1'b1) else begin
            $display("Fail %0t: led0_g low during an echoed frame", $time);
            errors++;
        end
        for (int i = 0; i < 8; i++) begin
            repeat (cpb) @(negedge sysclk);
            b[i] = uart_rxd_out;
        end
        repeat (cpb) @(negedge sysclk);
        assert (uart_rxd_out == 1'b1) else begin
            $display("Fail %0t: echoed frame has no stop bit", $time);
            errors++;
        end
        got_q.push_back(b);
    end

    //##########################################################################
    // checks
    //##########################################################################

    task automatic check_bit(input string what, input logic got, input logic exp,
                             inout int bad);
        assert (got === exp) else begin
            $display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
            bad++;
        end
    endtask

    task automatic check_echo(inout int bad);
        while (got_q.size() < exp_q.size())
            @(negedge sysclk);
        foreach (exp_q[i]) begin
            assert (got_q[i] == exp_q[i]) else begin
                $display("Fail %0t: echo %0d is %02h, expected %02h",
                         $time, i, got_q[i], exp_q[i]);
                bad++;
            end
        end
        exp_q.delete();
        got_q.delete();
    endtask

    task automatic check_blink(inout int bad);
        int   t0;
        logic lvl;
        lvl = led[0];
        while (led[0] == lvl) @(negedge sysclk);
        t0 = cycles;
        for (int k = 0; k < 3; k++) begin
            lvl = led[0];
            while (led[0] == lvl) @(negedge sysclk);
            assert (cycles - t0 >= 249 && cycles - t0 <= 251) else begin
                $display("Fail %0t: led[0] held for %0d cycles", $time, cycles - t0);
                bad++;
            end
            t0 = cycles;
        end
    endtask

    task automatic finish_test(input string name, input int bad);
        tests++;
        errors += bad;
        if (bad == 0)
            passed++;
        $display("%s: %s", name, (bad == 0) ? "ok" : "mismatch");
    endtask

    initial begin
        int              bad;
        uart_pkg::byte_t edges [6];
        uart_pkg::byte_t rnd;
        edges       = '{8'h40, 8'h5b, 8'h60, 8'h7b, 8'h41, 8'h5a};
        rst_n       = 1'b0;
        btn         = '0;
        uart_txd_in = 1'b1;
        repeat (8) @(negedge sysclk);
        rst_n = 1'b1;
        @(negedge sysclk);

        bad = 0;
        check_bit("uart_rxd_out", uart_rxd_out, 1'b1, bad);
        check_bit("led[0]", led[0], 1'b0, bad);
        check_bit("led[1]", led[1], 1'b0, bad);
        check_bit("led0_r", led0_r, 1'b0, bad);
        check_bit("led0_g", led0_g, 1'b0, bad);
        check_bit("led0_b", led0_b, 1'b0, bad);
        finish_test("reset levels", bad);

        bad = 0;
        for (int k = 0; k < 16; k++) begin
            rnd = xorshift_byte();
            send_echoed(rnd, rnd);
        end
        check_echo(bad);
        finish_test("random echo", bad);

        bad = 0;
        btn[0] = 1'b1;
        for (int c = 0; c < 26; c++)
            send_echoed(uart_pkg::byte_t'(8'h61 + c), uart_pkg::byte_t'(8'h41 + c));
        foreach (edges[i])
            send_echoed(edges[i], edges[i]);  // neighbours of both letter ranges
        check_echo(bad);
        finish_test("uppercase", bad);

        bad = 0;
        btn[0] = 1'b0;
        for (int k = 0; k < 12; k++) begin
            rnd = xorshift_byte();
            send_echoed(rnd, rnd);
        end
        check_echo(bad);
        finish_test("burst of 12", bad);

        bad = 0;
        send_frame(xorshift_byte(), 1'b0);  // stop bit low
        uart_txd_in = 1'b1;
        repeat (cpb) @(negedge sysclk);
        check_bit("led[1]", led[1], 1'b1, bad);
        check_bit("led0_r", led0_r, 1'b1, bad);
        rnd = xorshift_byte();
        send_echoed(rnd, rnd);
        check_echo(bad);
        btn[1] = 1'b1;
        @(negedge sysclk);
        btn[1] = 1'b0;
        @(negedge sysclk);
        check_bit("led[1]", led[1], 1'b0, bad);
        check_bit("led0_r", led0_r, 1'b0, bad);
        finish_test("framing error", bad);

        bad = 0;
        check_blink(bad);
        finish_test("blink", bad);

        errors += dut.i_top.u_assertions.fail_cnt;
        $display("%0d tests, %0d passed, %0d errors", tests, passed, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
